// File: pipe_control.f
design/rv_isa_pkg.sv
design/pipe_ctrl_pkg.sv
design/instr_fields.sv
design/stage_tracker.sv
design/hazard_unit.sv
design/pipe_control.sv
sim/pipe_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pipeline control testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --timescale 1ns/100ps \
    --top-module pipe_control_tb \
    -f pipe_control.f \
    -o pipe_control_sim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/pipe_control_sim

// File: sim/pipe_control_tb.sv
`default_nettype none
`timescale 1ns/100ps

module pipe_control_tb
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;
();

    localparam logic [31:0] nop_word      = 32'h0000_0013;
    localparam logic [5:0]  ctrl_run      = 6'b111000;
    localparam logic [5:0]  ctrl_stall    = 6'b000100;
    localparam logic [5:0]  ctrl_redirect = 6'b111011;
    localparam int          reset_timeout = 16;
    localparam int          random_words  = 300;

    logic        clk;
    logic        rst;
    logic [31:0] d_instr;
    logic        d_valid;
    logic        branch;
    logic        branch_taken;
    logic        jump;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    logic        pc_en;
    logic        f_d_en;
    logic        d_e_en;
    logic        no_op;
    logic        pc_src;
    logic        flush;

    // software copy of the execute, memory and writeback records
    logic [reg_idx_w-1:0] mdl_rs1;
    logic [reg_idx_w-1:0] mdl_rs2;
    logic                 mdl_rs1_used;
    logic                 mdl_rs2_used;
    logic [reg_idx_w-1:0] mdl_rd [stage_cnt];
    logic                 mdl_wr [stage_cnt];
    logic                 mdl_ld [stage_cnt];
    // decode word held by a load-use stall
    logic                 held;

    pipe_control DUT (
        .clk          (clk),
        .rst          (rst),
        .d_instr      (d_instr),
        .d_valid      (d_valid),
        .branch       (branch),
        .branch_taken (branch_taken),
        .jump         (jump),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .pc_en        (pc_en),
        .f_d_en       (f_d_en),
        .d_e_en       (d_e_en),
        .no_op        (no_op),
        .pc_src       (pc_src),
        .flush        (flush)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_fwd(input string what, input fwd_sel_e got, input fwd_sel_e exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %s expected %s", $time, what, got.name(),
                     exp.name());
            stop_run("forwarding select mismatch");
        end
    endtask

    // bit order pc_en f_d_en d_e_en no_op pc_src flush
    task automatic check_ctrl(input string what, input logic [5:0] got, input logic [5:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_run("stall or redirect mismatch");
        end
    endtask

    function automatic logic [31:0] r_word(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, op_op};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [6:0] opc, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [4:0] imm_lo);
        return {7'b0000000, rs2, rs1, 3'b000, imm_lo, opc};
    endfunction

    function automatic logic [6:0] pick_opcode(input int k);
        case (k)
            0: return op_load;
            1: return op_store;
            2: return op_branch;
            3: return op_jal;
            4: return op_jalr;
            5: return op_lui;
            6: return op_auipc;
            7: return op_op_imm;
            default: return op_op;
        endcase
    endfunction

    // memory only forwards non-loads, writeback forwards any writer
    function automatic fwd_sel_e expected_fwd(input logic used, input logic [4:0] src);
        fwd_sel_e sel;
        sel = fwd_none;
        if (used && mdl_wr[1] && !mdl_ld[1] && (mdl_rd[1] == src)) begin
            sel = fwd_mem;
        end else if (used && mdl_wr[2] && (mdl_rd[2] == src)) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    task automatic clear_model();
        mdl_rs1      = '0;
        mdl_rs2      = '0;
        mdl_rs1_used = 1'b0;
        mdl_rs2_used = 1'b0;
        held         = 1'b0;
        for (int i = 0; i < stage_cnt; i++) begin
            mdl_rd[i] = '0;
            mdl_wr[i] = 1'b0;
            mdl_ld[i] = 1'b0;
        end
    endtask

    // one decode cycle, checked against the model before the next edge
    task automatic issue(input logic [31:0] word, input logic valid, input logic br,
                         input logic tk, input logic jp);
        logic [6:0]           opc;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic                 rs1_used;
        logic                 rs2_used;
        logic                 rd_write;
        logic                 is_load;
        logic                 redirect;
        @(posedge clk);
        #1;
        d_instr      = word;
        d_valid      = valid;
        branch       = br;
        branch_taken = tk;
        jump         = jp;
        #4;
        opc      = word[6:0];
        rd       = word[11:7];
        rs1      = word[19:15];
        rs2      = word[24:20];
        rs1_used = valid && (opc inside {op_op, op_op_imm, op_load, op_jalr, op_store,
                                         op_branch});
        rs2_used = valid && (opc inside {op_op, op_store, op_branch});
        rd_write = valid && (rd != '0) && (opc inside {op_op, op_op_imm, op_load, op_jal,
                                                       op_jalr, op_lui, op_auipc});
        is_load  = rd_write && (opc == op_load);
        redirect = (br && tk) || jp;
        held     = mdl_ld[0] && !redirect && ((rs1_used && (rs1 == mdl_rd[0])) ||
                                              (rs2_used && (rs2 == mdl_rd[0])));
        check_fwd("model fwd_a", fwd_a, expected_fwd(mdl_rs1_used, mdl_rs1));
        check_fwd("model fwd_b", fwd_b, expected_fwd(mdl_rs2_used, mdl_rs2));
        check_ctrl("model control", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush},
                   {!held, !held, !held, held, redirect, redirect});
        for (int i = stage_cnt - 1; i > 0; i--) begin
            mdl_rd[i] = mdl_rd[i-1];
            mdl_wr[i] = mdl_wr[i-1];
            mdl_ld[i] = mdl_ld[i-1];
        end
        mdl_rs1      = rs1;
        mdl_rs2      = rs2;
        mdl_rd[0]    = rd;
        // bubble on a stall or a flush
        mdl_rs1_used = rs1_used && !held && !redirect;
        mdl_rs2_used = rs2_used && !held && !redirect;
        mdl_wr[0]    = rd_write && !held && !redirect;
        mdl_ld[0]    = is_load && !held && !redirect;
    endtask

    task automatic issue_plain(input logic [31:0] word);
        issue(word, 1'b1, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic drain();
        repeat (stage_cnt) issue_plain(nop_word);
    endtask

    task automatic apply_reset();
        int waited;
        rst = 1'b1;
        clear_model();
        repeat (2) @(posedge clk);
        #1;
        rst    = 1'b0;
        waited = 0;
        while (!(pc_en && d_e_en && !no_op && !flush) && (waited < reset_timeout)) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= reset_timeout) begin
            stop_run("pipeline control did not leave reset in time");
        end
    endtask

    task automatic test_reset_state();
        issue(nop_word, 1'b0, 1'b0, 1'b0, 1'b0);
        check_fwd("reset fwd_a", fwd_a, fwd_none);
        check_fwd("reset fwd_b", fwd_b, fwd_none);
        check_ctrl("reset control", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush}, ctrl_run);
    endtask

    task automatic test_forwarding();
        drain();
        issue_plain(r_word(5'd1, 5'd2, 5'd3));
        issue_plain(r_word(5'd4, 5'd1, 5'd5));
        issue_plain(nop_word);
        check_fwd("back to back fwd_a", fwd_a, fwd_mem);
        check_fwd("back to back fwd_b", fwd_b, fwd_none);
        // one independent word between writer and reader
        issue_plain(r_word(5'd6, 5'd7, 5'd8));
        issue_plain(r_word(5'd9, 5'd10, 5'd11));
        issue_plain(r_word(5'd12, 5'd13, 5'd6));
        issue_plain(nop_word);
        check_fwd("gap of one fwd_b", fwd_b, fwd_wb);
        // two writers of x1, the younger one wins
        issue_plain(r_word(5'd1, 5'd2, 5'd3));
        issue_plain(r_word(5'd1, 5'd4, 5'd5));
        issue_plain(r_word(5'd14, 5'd1, 5'd1));
        issue_plain(nop_word);
        check_fwd("mem over wb fwd_a", fwd_a, fwd_mem);
        check_fwd("mem over wb fwd_b", fwd_b, fwd_mem);
    endtask

    task automatic test_load_use();
        drain();
        issue_plain(i_word(op_load, 5'd5, 5'd2, 12'd0));
        issue_plain(r_word(5'd6, 5'd5, 5'd3));
        check_ctrl("load-use stall", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush},
                   ctrl_stall);
        // consumer held in decode for one more cycle
        issue_plain(r_word(5'd6, 5'd5, 5'd3));
        check_ctrl("after stall", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush}, ctrl_run);
        issue_plain(nop_word);
        check_fwd("load result fwd_a", fwd_a, fwd_wb);
        // imm bits in the rs2 field of an I-type word
        issue_plain(i_word(op_load, 5'd5, 5'd2, 12'd0));
        issue_plain(i_word(op_op_imm, 5'd7, 5'd8, 12'h005));
        check_ctrl("I-type rs2 field", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush}, ctrl_run);
    endtask

    task automatic test_no_producer();
        drain();
        issue_plain(r_word(5'd0, 5'd1, 5'd2));
        issue_plain(r_word(5'd3, 5'd0, 5'd0));
        issue_plain(r_word(5'd4, 5'd0, 5'd0));
        check_fwd("x0 mem fwd_a", fwd_a, fwd_none);
        check_fwd("x0 mem fwd_b", fwd_b, fwd_none);
        issue_plain(i_word(op_load, 5'd0, 5'd2, 12'd0));
        check_fwd("x0 wb fwd_a", fwd_a, fwd_none);
        issue_plain(r_word(5'd5, 5'd0, 5'd0));
        check_ctrl("load to x0", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush}, ctrl_run);
        // store and branch imm_lo equal to 3
        issue_plain(s_word(op_store, 5'd1, 5'd2, 5'd3));
        issue_plain(s_word(op_branch, 5'd1, 5'd2, 5'd3));
        issue_plain(r_word(5'd6, 5'd3, 5'd3));
        issue_plain(nop_word);
        check_fwd("store branch fwd_a", fwd_a, fwd_none);
        check_fwd("store branch fwd_b", fwd_b, fwd_none);
    endtask

    task automatic test_redirect();
        drain();
        issue_plain(s_word(op_branch, 5'd0, 5'd0, 5'd0));
        issue(r_word(5'd1, 5'd2, 5'd3), 1'b1, 1'b1, 1'b1, 1'b0);
        check_ctrl("taken branch", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush},
                   ctrl_redirect);
        issue_plain(r_word(5'd4, 5'd1, 5'd1));
        issue_plain(nop_word);
        check_fwd("flushed writer", fwd_a, fwd_none);
        issue(r_word(5'd1, 5'd2, 5'd3), 1'b1, 1'b0, 1'b0, 1'b1);
        check_ctrl("jump", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush}, ctrl_redirect);
        issue_plain(r_word(5'd4, 5'd1, 5'd1));
        issue_plain(nop_word);
        check_fwd("jump flushed writer", fwd_b, fwd_none);
        issue(r_word(5'd1, 5'd2, 5'd3), 1'b1, 1'b1, 1'b0, 1'b0);
        check_ctrl("not taken", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush}, ctrl_run);
        issue_plain(r_word(5'd4, 5'd1, 5'd1));
        issue_plain(nop_word);
        check_fwd("not taken fwd_a", fwd_a, fwd_mem);
        // redirect beats a load-use stall
        issue_plain(i_word(op_load, 5'd5, 5'd2, 12'd0));
        issue(r_word(5'd6, 5'd5, 5'd3), 1'b1, 1'b0, 1'b0, 1'b1);
        check_ctrl("jump over stall", {pc_en, f_d_en, d_e_en, no_op, pc_src, flush},
                   ctrl_redirect);
    endtask

    task automatic test_random();
        logic [31:0] word;
        logic        valid;
        word  = nop_word;
        valid = 1'b0;
        for (int n = 0; n < random_words; n++) begin
            if (!held) begin
                word        = $urandom();
                word[6:0]   = pick_opcode($urandom_range(0, 8));
                word[11:7]  = 5'($urandom_range(0, 3));
                word[19:15] = 5'($urandom_range(0, 3));
                word[24:20] = 5'($urandom_range(0, 3));
                valid       = ($urandom_range(0, 7) != 0);
            end
            issue(word, valid, ($urandom_range(0, 3) == 0), 1'($urandom_range(0, 1)),
                  ($urandom_range(0, 7) == 0));
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        d_instr      = '0;
        d_valid      = 1'b0;
        branch       = 1'b0;
        branch_taken = 1'b0;
        jump         = 1'b0;
        void'($urandom(32'ha90c_9e6a));
        apply_reset();
        test_reset_state();
        test_forwarding();
        test_load_use();
        test_no_producer();
        test_redirect();
        test_random();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/pipe_control.sv
`default_nettype none
`timescale 1ns/100ps

module pipe_control
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] d_instr,
    input  logic        d_valid,
    input  logic        branch,
    input  logic        branch_taken,
    input  logic        jump,

    output fwd_sel_e    fwd_a,
    output fwd_sel_e    fwd_b,
    output logic        pc_en,
    output logic        f_d_en,
    output logic        d_e_en,
    output logic        no_op,
    output logic        pc_src,
    output logic        flush
);

    // decode uses
    logic [reg_idx_w-1:0] d_rs1;
    logic                 d_rs1_used;
    logic [reg_idx_w-1:0] d_rs2;
    logic                 d_rs2_used;
    logic [reg_idx_w-1:0] d_rd;
    logic                 d_rd_write;
    logic                 d_is_load;

    // shadow records
    logic [reg_idx_w-1:0] e_rs1;
    logic                 e_rs1_used;
    logic [reg_idx_w-1:0] e_rs2;
    logic                 e_rs2_used;
    logic [reg_idx_w-1:0] e_rd;
    logic                 e_is_load;
    logic [reg_idx_w-1:0] m_rd;
    logic                 m_rd_write;
    logic                 m_is_load;
    logic [reg_idx_w-1:0] w_rd;
    logic                 w_rd_write;

    instr_fields u_fields (
        .d_instr    (d_instr),
        .d_valid    (d_valid),
        .d_rs1      (d_rs1),
        .d_rs1_used (d_rs1_used),
        .d_rs2      (d_rs2),
        .d_rs2_used (d_rs2_used),
        .d_rd       (d_rd),
        .d_rd_write (d_rd_write),
        .d_is_load  (d_is_load)
    );

    stage_tracker u_tracker (
        .clk        (clk),
        .rst        (rst),
        .d_e_en     (d_e_en),
        .flush      (flush),
        .d_rs1      (d_rs1),
        .d_rs1_used (d_rs1_used),
        .d_rs2      (d_rs2),
        .d_rs2_used (d_rs2_used),
        .d_rd       (d_rd),
        .d_rd_write (d_rd_write),
        .d_is_load  (d_is_load),
        .e_rs1      (e_rs1),
        .e_rs1_used (e_rs1_used),
        .e_rs2      (e_rs2),
        .e_rs2_used (e_rs2_used),
        .e_rd       (e_rd),
        .e_is_load  (e_is_load),
        .m_rd       (m_rd),
        .m_rd_write (m_rd_write),
        .m_is_load  (m_is_load),
        .w_rd       (w_rd),
        .w_rd_write (w_rd_write)
    );

    hazard_unit u_hazard (
        .d_rs1        (d_rs1),
        .d_rs1_used   (d_rs1_used),
        .d_rs2        (d_rs2),
        .d_rs2_used   (d_rs2_used),
        .e_rs1        (e_rs1),
        .e_rs1_used   (e_rs1_used),
        .e_rs2        (e_rs2),
        .e_rs2_used   (e_rs2_used),
        .e_rd         (e_rd),
        .e_is_load    (e_is_load),
        .m_rd         (m_rd),
        .m_rd_write   (m_rd_write),
        .m_is_load    (m_is_load),
        .w_rd         (w_rd),
        .w_rd_write   (w_rd_write),
        .branch       (branch),
        .branch_taken (branch_taken),
        .jump         (jump),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .pc_en        (pc_en),
        .f_d_en       (f_d_en),
        .d_e_en       (d_e_en),
        .no_op        (no_op),
        .pc_src       (pc_src),
        .flush        (flush)
    );

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
`default_nettype none
`timescale 1ns/100ps

module hazard_unit
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    // sources of the word in decode
    input  logic [reg_idx_w-1:0] d_rs1,
    input  logic                 d_rs1_used,
    input  logic [reg_idx_w-1:0] d_rs2,
    input  logic                 d_rs2_used,

    // execute stage record
    input  logic [reg_idx_w-1:0] e_rs1,
    input  logic                 e_rs1_used,
    input  logic [reg_idx_w-1:0] e_rs2,
    input  logic                 e_rs2_used,
    input  logic [reg_idx_w-1:0] e_rd,
    input  logic                 e_is_load,

    // memory stage record
    input  logic [reg_idx_w-1:0] m_rd,
    input  logic                 m_rd_write,
    input  logic                 m_is_load,

    // writeback stage record
    input  logic [reg_idx_w-1:0] w_rd,
    input  logic                 w_rd_write,

    // resolution from execute
    input  logic                 branch,
    input  logic                 branch_taken,
    input  logic                 jump,

    output fwd_sel_e             fwd_a,
    output fwd_sel_e             fwd_b,

    output logic                 pc_en,
    output logic                 f_d_en,
    output logic                 d_e_en,
    output logic                 no_op,

    output logic                 pc_src,
    output logic                 flush
);

    logic mem_fwd_ok;
    logic rs1_hit;
    logic rs2_hit;
    logic load_use;
    logic redirect;
    logic stall;

    // the youngest writer wins, memory before writeback
    function automatic fwd_sel_e pick_src(
        input logic                 used,
        input logic [reg_idx_w-1:0] src,
        input logic                 mem_ok,
        input logic [reg_idx_w-1:0] mem_rd,
        input logic                 wb_ok,
        input logic [reg_idx_w-1:0] wb_rd
    );
        fwd_sel_e sel;
        sel = fwd_none;
        if (used && mem_ok && (src == mem_rd)) begin
            sel = fwd_mem;
        end else if (used && wb_ok && (src == wb_rd)) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    // load data is not available yet in memory
    assign mem_fwd_ok = m_rd_write && !m_is_load;

    assign fwd_a = pick_src(e_rs1_used, e_rs1, mem_fwd_ok, m_rd, w_rd_write, w_rd);
    assign fwd_b = pick_src(e_rs2_used, e_rs2, mem_fwd_ok, m_rd, w_rd_write, w_rd);

    // load in execute feeding the word in decode
    assign rs1_hit  = d_rs1_used && (d_rs1 == e_rd);
    assign rs2_hit  = d_rs2_used && (d_rs2 == e_rd);
    assign load_use = e_is_load && (rs1_hit || rs2_hit);

    assign redirect = (branch && branch_taken) || jump;

    // a redirect discards the stalled consumer anyway
    assign stall = load_use && !redirect;

    assign pc_en  = !stall;
    assign f_d_en = !stall;
    assign d_e_en = !stall;
    assign no_op  = stall;

    assign pc_src = redirect;
    assign flush  = redirect;

endmodule

`default_nettype wire

// File: design/stage_tracker.sv
`default_nettype none
`timescale 1ns/100ps

module stage_tracker
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 d_e_en,
    input  logic                 flush,

    input  logic [reg_idx_w-1:0] d_rs1,
    input  logic                 d_rs1_used,
    input  logic [reg_idx_w-1:0] d_rs2,
    input  logic                 d_rs2_used,
    input  logic [reg_idx_w-1:0] d_rd,
    input  logic                 d_rd_write,
    input  logic                 d_is_load,

    output logic [reg_idx_w-1:0] e_rs1,
    output logic                 e_rs1_used,
    output logic [reg_idx_w-1:0] e_rs2,
    output logic                 e_rs2_used,
    output logic [reg_idx_w-1:0] e_rd,
    output logic                 e_is_load,

    output logic [reg_idx_w-1:0] m_rd,
    output logic                 m_rd_write,
    output logic                 m_is_load,

    output logic [reg_idx_w-1:0] w_rd,
    output logic                 w_rd_write
);

    logic                 take_d;

    // sources only matter while in execute
    logic [reg_idx_w-1:0] rs1_q;
    logic [reg_idx_w-1:0] rs2_q;
    logic                 rs1_used_q;
    logic                 rs2_used_q;

    // destination side, one entry per tracked stage
    logic [reg_idx_w-1:0] rd_q [stage_cnt];
    logic                 wr_q [stage_cnt];

    // load flag is dropped once it reaches writeback
    logic                 ld_q [stg_w];

    // stall or flush sends a bubble into execute
    assign take_d = d_e_en && !flush;

    always_ff @(posedge clk) begin
        rs1_q       <= d_rs1;
        rs2_q       <= d_rs2;
        rd_q[stg_e] <= d_rd;
        for (int i = 1; i < stage_cnt; i++) begin
            rd_q[i] <= rd_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rs1_used_q  <= 1'b0;
            rs2_used_q  <= 1'b0;
            ld_q[stg_e] <= 1'b0;
            ld_q[stg_m] <= 1'b0;
            for (int i = 0; i < stage_cnt; i++) begin
                wr_q[i] <= 1'b0;
            end
        end else begin
            rs1_used_q  <= take_d && d_rs1_used;
            rs2_used_q  <= take_d && d_rs2_used;
            wr_q[stg_e] <= take_d && d_rd_write;
            ld_q[stg_e] <= take_d && d_is_load;
            // M and W always advance
            for (int i = 1; i < stage_cnt; i++) begin
                wr_q[i] <= wr_q[i-1];
            end
            ld_q[stg_m] <= ld_q[stg_e];
        end
    end

    assign e_rs1      = rs1_q;
    assign e_rs1_used = rs1_used_q;
    assign e_rs2      = rs2_q;
    assign e_rs2_used = rs2_used_q;
    assign e_rd       = rd_q[stg_e];
    assign e_is_load  = ld_q[stg_e];

    assign m_rd       = rd_q[stg_m];
    assign m_rd_write = wr_q[stg_m];
    assign m_is_load  = ld_q[stg_m];

    assign w_rd       = rd_q[stg_w];
    assign w_rd_write = wr_q[stg_w];

endmodule

`default_nettype wire

// File: design/instr_fields.sv
`default_nettype none
`timescale 1ns/100ps

module instr_fields
    import rv_isa_pkg::*;
(
    input  rv_instr_u            d_instr,
    input  logic                 d_valid,

    output logic [reg_idx_w-1:0] d_rs1,
    output logic                 d_rs1_used,
    output logic [reg_idx_w-1:0] d_rs2,
    output logic                 d_rs2_used,
    output logic [reg_idx_w-1:0] d_rd,
    output logic                 d_rd_write,
    output logic                 d_is_load
);

    logic [opcode_w-1:0] opcode;
    logic                s_type;
    logic                rs1_op;
    logic                rd_op;
    logic                has_dest;
    logic                rd_nz;

    assign opcode = d_instr.r_form.opcode;

    // stores and branches carry imm bits where rd would be
    assign s_type = (d_instr.s_form.opcode == op_store) ||
                    (d_instr.s_form.opcode == op_branch);

    // per-opcode source and destination use
    always_comb begin
        rs1_op = 1'b0;
        rd_op  = 1'b0;
        case (opcode)
            op_op, op_op_imm, op_load, op_jalr: begin
                rs1_op = 1'b1;
                rd_op  = 1'b1;
            end
            op_store, op_branch: begin
                rs1_op = 1'b1;
            end
            op_jal, op_lui, op_auipc: begin
                rd_op = 1'b1;
            end
            default: begin
                rs1_op = 1'b0;
                rd_op  = 1'b0;
            end
        endcase
    end

    assign has_dest = rd_op && !s_type;
    assign d_rd     = has_dest ? d_instr.r_form.rd : '0;
    assign rd_nz    = (d_rd != '0);

    assign d_rs1 = d_instr.r_form.rs1;
    assign d_rs2 = d_instr.r_form.rs2;

    assign d_rs1_used = d_valid && rs1_op;
    assign d_rs2_used = d_valid && ((opcode == op_op) || s_type);

    // writes to x0 are dropped here, nothing downstream checks for it
    assign d_rd_write = d_valid && has_dest && rd_nz;
    assign d_is_load  = d_valid && (opcode == op_load) && rd_nz;

endmodule

`default_nettype wire

// File: design/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    // operand source select for the execute stage muxes
    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_mem  = 2'b01,
        fwd_wb   = 2'b10
    } fwd_sel_e;

    // stages tracked after decode
    localparam int stage_cnt = 3;

    // position of each stage in the shadow record arrays
    localparam int stg_e = 0;
    localparam int stg_m = 1;
    localparam int stg_w = 2;

endpackage

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // register file index and opcode field widths
    localparam int reg_idx_w = 5;
    localparam int opcode_w  = 7;

    // RV32I major opcodes
    localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] op_store  = 7'b0100011;
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] op_auipc  = 7'b0010111;
    localparam logic [opcode_w-1:0] op_op_imm = 7'b0010011;
    localparam logic [opcode_w-1:0] op_op     = 7'b0110011;

    // bits 11:7 hold rd for most formats
    // but the low immediate bits for stores and branches
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [reg_idx_w-1:0] rs2;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [reg_idx_w-1:0] rd;
            logic [opcode_w-1:0]  opcode;
        } r_form;
        struct packed {
            logic [6:0]           imm_hi;
            logic [reg_idx_w-1:0] rs2;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [4:0]           imm_lo;
            logic [opcode_w-1:0]  opcode;
        } s_form;
    } rv_instr_u;

endpackage

`default_nettype wire
